// ==== src/disp_pkg.sv ====
`default_nettype none

package disp_pkg;

  // ----------------------------------------------------------------------
  // register map, word offsets on the 8-bit apb address
  // ----------------------------------------------------------------------
  localparam logic [7:0] ADDR_DISP = 8'h00;
  localparam logic [7:0] ADDR_CTRL = 8'h04;
  localparam logic [7:0] ADDR_DUTY = 8'h08;

  // ----------------------------------------------------------------------
  // digit codes
  // ----------------------------------------------------------------------
  // 0 to 9 are numerals, 11 to 14 show blank as well
  typedef logic [3:0] digit_code_t;

  localparam digit_code_t CODE_MINUS = 4'd10;
  localparam digit_code_t CODE_BLANK = 4'd15;

  // element 0 is the units digit (rightmost)
  typedef digit_code_t [3:0] digits_t;

  // ----------------------------------------------------------------------
  // display word, read as signed decimal or as raw digit codes
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic [7:0]        unused;
    logic signed [7:0] value;
  } disp_dec_t;

  typedef union packed {
    disp_dec_t dec;
    digits_t   raw;
  } disp_word_u;

  // configuration from the register block, 26 bits
  typedef struct packed {
    disp_word_u  word;
    logic        raw_mode;
    logic        enable;
    logic [7:0]  duty;
  } disp_cfg_t;

endpackage

`default_nettype wire

// ==== src/disp_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module disp_apb_regs (
  input  wire logic                 clk_1000hz,
  input  wire logic                 rst_i,
  // apb slave
  input  wire logic                 psel_i,
  input  wire logic                 penable_i,
  input  wire logic                 pwrite_i,
  input  wire logic [7:0]           paddr_i,
  input  wire logic [31:0]          pwdata_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  // configuration to the datapath
  output disp_pkg::disp_cfg_t       cfg_o
);

  // ----------------------------------------------------------------------
  // address decode
  // ----------------------------------------------------------------------
  logic hit_disp;
  logic hit_ctrl;
  logic hit_duty;
  logic addr_hit;
  logic access;
  logic wr_en;

  disp_pkg::disp_cfg_t cfg_q;

  assign hit_disp = (paddr_i == disp_pkg::ADDR_DISP);
  assign hit_ctrl = (paddr_i == disp_pkg::ADDR_CTRL);
  assign hit_duty = (paddr_i == disp_pkg::ADDR_DUTY);
  assign addr_hit = hit_disp | hit_ctrl | hit_duty;

  // access phase, no wait states
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i & addr_hit;

  assign pready_o  = access;
  // unmapped address flagged only during the access phase
  assign pslverr_o = access & ~addr_hit;

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------
  // write lands on the edge that closes the access phase
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      cfg_q <= '0;
    end else if (wr_en) begin
      if (hit_disp) begin
        cfg_q.word <= pwdata_i[15:0];
      end
      if (hit_ctrl) begin
        cfg_q.raw_mode <= pwdata_i[0];
        cfg_q.enable   <= pwdata_i[1];
      end
      if (hit_duty) begin
        cfg_q.duty <= pwdata_i[7:0];
      end
    end
  end

  // ----------------------------------------------------------------------
  // read back
  // ----------------------------------------------------------------------
  // unused bits read as zero
  always_comb begin
    prdata_o = '0;
    if (hit_disp) begin
      prdata_o[15:0] = cfg_q.word;
    end
    if (hit_ctrl) begin
      prdata_o[1:0] = {cfg_q.enable, cfg_q.raw_mode};
    end
    if (hit_duty) begin
      prdata_o[7:0] = cfg_q.duty;
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

// ==== src/bin_to_digits.sv ====
`timescale 1ns/1ps
`default_nettype none

module bin_to_digits (
  input  disp_pkg::disp_cfg_t cfg_i,
  output disp_pkg::digits_t   digits_o
);

  // ----------------------------------------------------------------------
  // decimal decode of the signed view
  // ----------------------------------------------------------------------
  logic signed [7:0]     value;
  logic                  negative;
  logic [7:0]            mag;
  disp_pkg::digit_code_t hundreds;
  disp_pkg::digit_code_t tens;
  disp_pkg::digit_code_t units;
  disp_pkg::digits_t     dec_digits;

  assign value    = cfg_i.word.dec.value;
  assign negative = value[7];

  // magnitude fits in 8 bits unsigned, even for -128
  assign mag = negative ? (~value + 8'd1) : value;

  // split into hundreds, tens, units
  assign hundreds = 4'(mag / 8'd100);
  assign tens     = 4'((mag % 8'd100) / 8'd10);
  assign units    = 4'(mag % 8'd10);

  always_comb begin
    dec_digits[0] = units;
    dec_digits[1] = tens;
    dec_digits[2] = hundreds;
    // sign in the leftmost position
    dec_digits[3] = negative ? disp_pkg::CODE_MINUS : disp_pkg::CODE_BLANK;

    // blank leading zeros, units always shown
    if (hundreds == 4'd0) begin
      dec_digits[2] = disp_pkg::CODE_BLANK;
      if (tens == 4'd0) begin
        dec_digits[1] = disp_pkg::CODE_BLANK;
      end
    end
  end

  // ----------------------------------------------------------------------
  // mode select
  // ----------------------------------------------------------------------
  // raw view goes straight through
  assign digits_o = cfg_i.raw_mode ? cfg_i.word.raw : dec_digits;

endmodule

`default_nettype wire

// ==== src/brightness_pwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module brightness_pwm (
  input  wire logic       clk_1000hz,
  input  wire logic       rst_i,
  input  wire logic [7:0] duty_i,
  output logic            pwm_o
);

  // ----------------------------------------------------------------------
  // free-running period counter
  // ----------------------------------------------------------------------
  logic [7:0] cnt_q;

  // wraps 255 -> 0 on its own
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      cnt_q <= 8'd0;
    end else begin
      cnt_q <= cnt_q + 8'd1;
    end
  end

  // on for exactly duty_i counts per 256
  // duty 0 never on, 255 on for 255 of 256
  assign pwm_o = (cnt_q < duty_i);

endmodule

`default_nettype wire

// ==== src/digit_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module digit_scanner #(
  parameter int SCAN_DIV = 4
) (
  input  wire logic               clk_1000hz,
  input  wire logic               rst_i,
  input  disp_pkg::digits_t       digits_i,
  input  wire logic               enable_i,
  input  wire logic               pwm_i,
  output logic [3:0]              an_o,
  output logic [6:0]              seg_o
);

  // prescaler needs at least one bit
  localparam int DIV_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

  // ----------------------------------------------------------------------
  // prescaler and digit index
  // ----------------------------------------------------------------------
  logic [DIV_W-1:0]      div_q;
  logic                  div_wrap;
  logic [1:0]            idx_q;
  disp_pkg::digit_code_t code;
  logic [6:0]            glyph;

  assign div_wrap = (div_q == DIV_W'(SCAN_DIV - 1));

  // index holds for SCAN_DIV clocks, wraps 0..3
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      div_q <= '0;
      idx_q <= 2'd0;
    end else if (div_wrap) begin
      div_q <= '0;
      idx_q <= idx_q + 2'd1;
    end else begin
      div_q <= div_q + DIV_W'(1);
    end
  end

  // ----------------------------------------------------------------------
  // segment encode, seg order g..a, active low
  // ----------------------------------------------------------------------
  assign code = digits_i[idx_q];

  always_comb begin
    case (code)
      4'd0:    glyph = 7'b1000000;
      4'd1:    glyph = 7'b1111001;
      4'd2:    glyph = 7'b0100100;
      4'd3:    glyph = 7'b0110000;
      4'd4:    glyph = 7'b0011001;
      4'd5:    glyph = 7'b0010010;
      4'd6:    glyph = 7'b0000010;
      4'd7:    glyph = 7'b1111000;
      4'd8:    glyph = 7'b0000000;
      4'd9:    glyph = 7'b0010000;
      // minus lights g only
      disp_pkg::CODE_MINUS: glyph = 7'b0111111;
      // 11 to 15 are blank
      default: glyph = 7'b1111111;
    endcase
  end

  // ----------------------------------------------------------------------
  // output registers
  // ----------------------------------------------------------------------
  // anode and segments move together
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      an_o  <= 4'b1111;
      seg_o <= 7'b1111111;
    end else begin
      seg_o <= glyph;
      // digit k pulls anode bit 3-k low
      if (enable_i && pwm_i) begin
        an_o <= ~(4'b1000 >> idx_q);
      end else begin
        an_o <= 4'b1111;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/disp_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module disp_subsys_top #(
  // clocks each digit is held
  parameter int SCAN_DIV = 4
) (
  input  wire logic        clk_1000hz,
  input  wire logic        rst_i,
  // apb slave
  input  wire logic        psel_i,
  input  wire logic        penable_i,
  input  wire logic        pwrite_i,
  input  wire logic [7:0]  paddr_i,
  input  wire logic [31:0] pwdata_i,
  output logic [31:0]      prdata_o,
  output logic             pready_o,
  output logic             pslverr_o,
  // display pins, active low
  output logic [3:0]       an_o,
  output logic [6:0]       seg_o
);

  // ----------------------------------------------------------------------
  // internal links
  // ----------------------------------------------------------------------
  disp_pkg::disp_cfg_t cfg;
  disp_pkg::digits_t   digits;
  logic                pwm_on;

  // register block
  disp_apb_regs regs_0 (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .paddr_i    (paddr_i),
    .pwdata_i   (pwdata_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .cfg_o      (cfg)
  );

  // word to digit codes
  bin_to_digits bin_to_digits_0 (
    .cfg_i      (cfg),
    .digits_o   (digits)
  );

  // brightness
  brightness_pwm pwm_0 (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .duty_i     (cfg.duty),
    .pwm_o      (pwm_on)
  );

  // multiplex and segment encode
  digit_scanner #(
    .SCAN_DIV   (SCAN_DIV)
  ) scanner_0 (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .digits_i   (digits),
    .enable_i   (cfg.enable),
    .pwm_i      (pwm_on),
    .an_o       (an_o),
    .seg_o      (seg_o)
  );

endmodule

`default_nettype wire

// ==== tb/tb_disp_subsys.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_disp_subsys;

  localparam int SCAN_DIV = 4;
  localparam int N_ENTRIES = 10;

  // word, raw_mode, expected codes (element 0 is units)
  typedef struct packed {
    logic [15:0]       word;
    logic              raw;
    disp_pkg::digits_t exp;
  } entry_t;

  logic        clk_1000hz;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic [3:0]  an;
  logic [6:0]  seg;

  entry_t      tbl [N_ENTRIES];
  int          errors;
  int          timeouts;
  int          i;
  int          n;
  int          k;
  int          cnt;
  logic [3:0]  seen;
  logic [31:0] rng;
  logic [7:0]  duty;

  disp_subsys_top #(
    .SCAN_DIV   (SCAN_DIV)
  ) dut0 (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst),
    .psel_i     (psel),
    .penable_i  (penable),
    .pwrite_i   (pwrite),
    .paddr_i    (paddr),
    .pwdata_i   (pwdata),
    .prdata_o   (prdata),
    .pready_o   (pready),
    .pslverr_o  (pslverr),
    .an_o       (an),
    .seg_o      (seg)
  );

  initial begin
    clk_1000hz = 1'b0;
    forever #50 clk_1000hz = ~clk_1000hz;
  end

  // ----------------------------------------------------------------------
  // reference helpers
  // ----------------------------------------------------------------------
  // lit segments as gfedcba, inverted for the common anode part
  function automatic logic [6:0] glyph(input logic [3:0] code);
    logic [6:0] lit;
    case (code)
      4'd0:    lit = 7'b0111111;
      4'd1:    lit = 7'b0000110;
      4'd2:    lit = 7'b1011011;
      4'd3:    lit = 7'b1001111;
      4'd4:    lit = 7'b1100110;
      4'd5:    lit = 7'b1101101;
      4'd6:    lit = 7'b1111101;
      4'd7:    lit = 7'b0000111;
      4'd8:    lit = 7'b1111111;
      4'd9:    lit = 7'b1101111;
      4'd10:   lit = 7'b1000000;
      default: lit = 7'b0000000;
    endcase
    return ~lit;
  endfunction

  // digit position of a single low anode, -1 otherwise
  // digit k owns anode bit 3-k
  function automatic int low_pos(input logic [3:0] a);
    case (a)
      4'b0111: return 0;
      4'b1011: return 1;
      4'b1101: return 2;
      4'b1110: return 3;
      default: return -1;
    endcase
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // ----------------------------------------------------------------------
  // apb access, no wait states expected
  // ----------------------------------------------------------------------
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic [31:0] exp_rdata, input logic exp_err);
    int w;
    @(posedge clk_1000hz);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= data;
    @(posedge clk_1000hz);
    penable <= 1'b1;
    @(negedge clk_1000hz);
    w = 0;
    while (pready !== 1'b1 && w < 8) begin
      @(negedge clk_1000hz);
      w++;
    end
    if (pready !== 1'b1) begin
      $display("timeout: pready stayed low on access to addr %h", addr);
      timeouts++;
    end
    if (pslverr !== exp_err) begin
      $display("FAIL %0t: pslverr %b on addr %h, expected %b", $time, pslverr, addr, exp_err);
      errors++;
    end
    if (!wr && prdata !== exp_rdata) begin
      $display("FAIL %0t: read addr %h gave %h, expected %h", $time, addr, prdata, exp_rdata);
      errors++;
    end
    @(posedge clk_1000hz);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // counts cycles with any anode low over one pwm period
  task automatic count_lit(output int lit);
    lit = 0;
    repeat (256) begin
      @(negedge clk_1000hz);
      if (an != 4'b1111) begin
        lit++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    rst     = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = 8'h00;
    pwdata  = 32'h0;
    errors   = 0;
    timeouts = 0;
    rng      = 32'h751;

    // decimal entries, upper byte of 42 is ignored
    tbl[0] = {16'h0000, 1'b0, 16'hFFF0};
    tbl[1] = {16'h0005, 1'b0, 16'hFFF5};
    tbl[2] = {16'h5A2A, 1'b0, 16'hFF42};
    tbl[3] = {16'h0064, 1'b0, 16'hF100};
    tbl[4] = {16'h007F, 1'b0, 16'hF127};
    tbl[5] = {16'h00FF, 1'b0, 16'hAFF1};
    tbl[6] = {16'h00FB, 1'b0, 16'hAFF5};
    tbl[7] = {16'h0080, 1'b0, 16'hA128};
    // raw entries, the -128 word and the minus and blank codes
    tbl[8] = {16'h0080, 1'b1, 16'h0080};
    tbl[9] = {16'hABEF, 1'b1, 16'hABEF};

    repeat (3) @(posedge clk_1000hz);
    rst <= 1'b1;

    // reset state
    @(negedge clk_1000hz);
    if (an !== 4'b1111 || seg !== 7'h7F || pready !== 1'b0 || pslverr !== 1'b0) begin
      $display("FAIL %0t: after reset an %b seg %b pready %b pslverr %b",
               $time, an, seg, pready, pslverr);
      errors++;
    end
    apb_access(1'b0, disp_pkg::ADDR_DISP, 32'h0, 32'h0, 1'b0);
    apb_access(1'b0, disp_pkg::ADDR_CTRL, 32'h0, 32'h0, 1'b0);
    apb_access(1'b0, disp_pkg::ADDR_DUTY, 32'h0, 32'h0, 1'b0);

    // register access, masked to width
    apb_access(1'b1, disp_pkg::ADDR_DISP, 32'hFFFF_1234, 32'h0, 1'b0);
    apb_access(1'b0, disp_pkg::ADDR_DISP, 32'h0, 32'h0000_1234, 1'b0);
    apb_access(1'b1, disp_pkg::ADDR_CTRL, 32'hFFFF_FFFF, 32'h0, 1'b0);
    apb_access(1'b0, disp_pkg::ADDR_CTRL, 32'h0, 32'h0000_0003, 1'b0);
    apb_access(1'b1, disp_pkg::ADDR_DUTY, 32'h1234_56C3, 32'h0, 1'b0);
    apb_access(1'b0, disp_pkg::ADDR_DUTY, 32'h0, 32'h0000_00C3, 1'b0);
    // unmapped write ignored, read zero
    apb_access(1'b1, 8'h0C, 32'hFFFF_FFFF, 32'h0, 1'b1);
    apb_access(1'b0, 8'h0C, 32'h0, 32'h0, 1'b1);
    apb_access(1'b0, disp_pkg::ADDR_DUTY, 32'h0, 32'h0000_00C3, 1'b0);

    // ----------------------------------------------------------------------
    // table of display words
    // ----------------------------------------------------------------------
    apb_access(1'b1, disp_pkg::ADDR_DUTY, 32'hFF, 32'h0, 1'b0);
    for (i = 0; i < N_ENTRIES; i++) begin
      apb_access(1'b1, disp_pkg::ADDR_DISP, {16'h0, tbl[i].word}, 32'h0, 1'b0);
      apb_access(1'b1, disp_pkg::ADDR_CTRL, {30'h0, 1'b1, tbl[i].raw}, 32'h0, 1'b0);
      repeat (2 * 4 * SCAN_DIV) @(posedge clk_1000hz);
      seen = 4'b0000;
      n = 0;
      while (seen != 4'b1111 && n < 400) begin
        @(negedge clk_1000hz);
        k = low_pos(an);
        if (k >= 0 && !seen[k]) begin
          if (seg !== glyph(tbl[i].exp[k])) begin
            $display("FAIL %0t: entry %0d digit %0d seg %b, expected %b",
                     $time, i, k, seg, glyph(tbl[i].exp[k]));
            errors++;
          end
          seen[k] = 1'b1;
        end
        n++;
      end
      if (seen != 4'b1111) begin
        $display("timeout: entry %0d never scanned all four digits", i);
        timeouts++;
      end
    end

    // gating, enable off then duty zero
    apb_access(1'b1, disp_pkg::ADDR_CTRL, 32'h0, 32'h0, 1'b0);
    repeat (2) @(posedge clk_1000hz);
    count_lit(cnt);
    count_lit(k);
    if (cnt + k != 0) begin
      $display("FAIL %0t: anodes active with enable off", $time);
      errors++;
    end
    apb_access(1'b1, disp_pkg::ADDR_CTRL, 32'h2, 32'h0, 1'b0);
    apb_access(1'b1, disp_pkg::ADDR_DUTY, 32'h0, 32'h0, 1'b0);
    repeat (2) @(posedge clk_1000hz);
    count_lit(cnt);
    count_lit(k);
    if (cnt + k != 0) begin
      $display("FAIL %0t: anodes active with duty zero", $time);
      errors++;
    end

    // brightness, 255 then three random duties
    for (i = 0; i < 4; i++) begin
      if (i == 0) begin
        duty = 8'hFF;
      end else begin
        rng  = xorshift(rng);
        duty = rng[7:0];
      end
      apb_access(1'b1, disp_pkg::ADDR_DUTY, {24'h0, duty}, 32'h0, 1'b0);
      repeat (2) @(posedge clk_1000hz);
      count_lit(cnt);
      if (cnt != duty) begin
        $display("FAIL %0t: duty %0d lit %0d cycles of 256", $time, duty, cnt);
        errors++;
      end
    end

    $display("errors: %0d wrong values, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== disp_subsys_top.f ====
src/disp_pkg.sv
src/disp_apb_regs.sv
src/bin_to_digits.sv
src/brightness_pwm.sv
src/digit_scanner.sv
src/disp_subsys_top.sv
tb/tb_disp_subsys.sv
